//--- files.f
rtl/scope_pkg.sv
rtl/scope_edge.sv
rtl/scope_acq.sv
rtl/scope_buf.sv
rtl/scope_top.sv
tests/scope_tb.sv

//--- run.sh
#!/bin/sh
# build and run the scope testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module scope_tb -Mdir obj_dir -f files.f

# the simulation may stop on $fatal, the log decides
./obj_dir/Vscope_tb 2>&1 | tee sim.log || true

if grep -q "^RESULT: PASS$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi

//--- tests/scope_tb.sv
/*
  testbench for the two-channel scope trigger and acquisition
  clock and reset, noisy ramp stimulus, level rule and capture model,
  buffer readout, assertions on trigger, done, pointer and data
*/

`default_nettype none

module scope_tb import scope_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  logic                    sti;
  logic                    ctl_rst;
  smp_t                    adc_a;
  smp_t                    adc_b;
  ch_cfg_t                 cfg_a;
  ch_cfg_t                 cfg_b;
  logic                    ctl_start_a;
  logic                    ctl_start_b;
  logic                    sts_trg_a;
  logic                    sts_trg_b;
  logic                    sts_done_a;
  logic                    sts_done_b;
  logic [5:0]              sts_ptr_a;
  logic [5:0]              sts_ptr_b;
  logic                    rd_en;
  logic [6:0]              rd_addr;
  logic signed [smp_w-1:0] rd_dat;

  // expected trigger, tagged on the strobe and delayed to the DUT output
  logic [1:0] exp_in;
  logic [1:0] exp_d1;
  logic [1:0] exp_d2;

  // expected done, tagged on the strobe and delayed past the capture pipeline
  logic [1:0] dn_in;
  logic [1:0] dn_d1;
  logic [1:0] dn_d2;
  logic [1:0] dn_d3;

  // channel model, index 0 is channel a
  logic [1:0] lvl;
  logic [1:0] armed;
  logic [1:0] trig_seen;
  logic [1:0] mdl_done;
  int         wptr [2];
  int         cnt [2];
  int         tptr [2];
  int         ntrg [2];
  int         cp [2][64];
  logic       known [2][64];

  int seed;
  int phase;

  scope_top #(.buf_aw(6)) DUT (.*);

  always #4 sti = ~sti;

  // two stage delay, same as the edge detector
  // done goes one stage further, through the controller
  always @(posedge sti) begin
    if (ctl_rst) begin
      exp_d1 <= '0;
      exp_d2 <= '0;
      dn_d1  <= '0;
      dn_d2  <= '0;
      dn_d3  <= '0;
    end else begin
      exp_d1 <= exp_in & {adc_b.vld, adc_a.vld};
      exp_d2 <= exp_d1;
      dn_d1  <= dn_in;
      dn_d2  <= dn_d1;
      dn_d3  <= dn_d2;
    end
  end

  //////////////////////////////
  // reporting
  //////////////////////////////

  task automatic stop_run(string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic report_error(string msg);
    stop_run($sformatf("** Error at %0d ns: %s", $time, msg));
  endtask

  //////////////////////////////
  // assertions
  //////////////////////////////

  a_trg_a: assert property (@(posedge sti) disable iff (ctl_rst) sts_trg_a == exp_d2[0])
    else report_error("channel a trigger differs from the level rule");
  a_trg_b: assert property (@(posedge sti) disable iff (ctl_rst) sts_trg_b == exp_d2[1])
    else report_error("channel b trigger differs from the level rule");
  // done not before the last post sample has left the pipeline
  a_done_a: assert property (@(posedge sti) disable iff (ctl_rst) sts_done_a |-> dn_d3[0])
    else report_error("channel a done before post samples");
  a_done_b: assert property (@(posedge sti) disable iff (ctl_rst) sts_done_b |-> dn_d3[1])
    else report_error("channel b done before post samples");

  //////////////////////////////
  // model
  //////////////////////////////

  // triangle, 16 steps up and 16 down
  function automatic int ramp(int k);
    int ph;
    ph = k % 32;
    if (ph < 16) return -640 + ph * 80;
    return 640 - (ph - 16) * 80;
  endfunction

  // returns {trigger, new level}
  function automatic logic [1:0] level_rule(int s, ch_cfg_t c, logic l);
    int p;
    int n;
    p = c.pos;
    n = c.neg;
    if (!l) begin
      if (c.edg ? (s < n) : (s > p)) return 2'b11;
    end else if (c.edg ? (s > p) : (s < n)) begin
      return 2'b00;
    end
    return {1'b0, l};
  endfunction

  task automatic model_acq(int ch, int s, logic t, int post);
    if (armed[ch] && !mdl_done[ch]) begin
      cp[ch][wptr[ch]] = s;
      known[ch][wptr[ch]] = 1'b1;
      if (trig_seen[ch]) begin
        cnt[ch]++;
        if (cnt[ch] == post) mdl_done[ch] = 1'b1;
      end else if (t) begin
        trig_seen[ch] = 1'b1;
        tptr[ch] = wptr[ch];
        if (post == 0) mdl_done[ch] = 1'b1;
      end
      wptr[ch] = (wptr[ch] + 1) % 64;
    end
  endtask

  //////////////////////////////
  // stimulus
  //////////////////////////////

  // one strobe, then one idle cycle
  task automatic drive_sample();
    int sa;
    int sb;
    logic [1:0] ra;
    logic [1:0] rb;
    sa = ramp(phase) + $random(seed) % 64;
    sb = ramp(phase) + $random(seed) % 64;
    phase++;
    ra = level_rule(sa, cfg_a, lvl[0]);
    rb = level_rule(sb, cfg_b, lvl[1]);
    lvl = {rb[0], ra[0]};
    ntrg[0] += ra[1];
    ntrg[1] += rb[1];
    model_acq(0, sa, ra[1], cfg_a.post);
    model_acq(1, sb, rb[1], cfg_b.post);
    @(posedge sti);
    adc_a  <= '{vld: 1'b1, dat: 14'(sa)};
    adc_b  <= '{vld: 1'b1, dat: 14'(sb)};
    exp_in <= {rb[1], ra[1]};
    dn_in  <= mdl_done;
    @(posedge sti);
    adc_a.vld <= 1'b0;
    adc_b.vld <= 1'b0;
  endtask

  // quiet pipeline first, so no sample is in flight at start
  task automatic arm_channel(int ch, logic edg, int pos, int neg, int post);
    ch_cfg_t c;
    c = '{edg: edg, pos: 14'(pos), neg: 14'(neg), post: 16'(post)};
    repeat (4) @(posedge sti);
    if (ch == 0) begin
      cfg_a       <= c;
      ctl_start_a <= 1'b1;
    end else begin
      cfg_b       <= c;
      ctl_start_b <= 1'b1;
    end
    @(posedge sti);
    ctl_start_a <= 1'b0;
    ctl_start_b <= 1'b0;
    @(posedge sti);
    armed[ch]     = 1'b1;
    trig_seen[ch] = 1'b0;
    mdl_done[ch]  = 1'b0;
    wptr[ch]      = 0;
    cnt[ch]       = 0;
    for (int a = 0; a < 64; a++) begin
      known[ch][a] = 1'b0;
    end
    assert ((ch == 0 ? sts_done_a : sts_done_b) == 1'b0)
      else report_error($sformatf("channel %0d done still high after start", ch));
  endtask

  task automatic capture_until_done();
    int n;
    n = 0;
    while (mdl_done != 2'b11) begin
      if (n == 400) stop_run("no capture completed within 400 samples");
      drive_sample();
      n++;
    end
    n = 0;
    while (!(sts_done_a && sts_done_b)) begin
      if (n == 16) stop_run("timeout waiting for sts_done");
      @(posedge sti);
      n++;
    end
  endtask

  // trigger pointer, then every slot the model wrote
  task automatic check_buffer(int ch);
    logic [5:0] ptr;
    ptr = (ch == 0) ? sts_ptr_a : sts_ptr_b;
    assert (ptr == 6'(tptr[ch]))
      else report_error($sformatf("ch %0d sts_ptr %0d expected %0d", ch, ptr, tptr[ch]));
    for (int a = 0; a < 64; a++) begin
      if (known[ch][a]) begin
        @(posedge sti);
        rd_en   <= 1'b1;
        rd_addr <= 7'(ch * 64 + a);
        @(posedge sti);
        rd_en <= 1'b0;
        @(posedge sti);
        assert (rd_dat == 14'(cp[ch][a]))
          else report_error($sformatf("ch %0d slot %0d read %0d expected %0d",
                                      ch, a, rd_dat, cp[ch][a]));
      end
    end
  endtask

  //////////////////////////////
  // sequence
  //////////////////////////////

  initial begin
    sti = 1'b0;
    ctl_rst = 1'b1;
    adc_a = '0;
    adc_b = '0;
    cfg_a = '{edg: 1'b0, pos: 14'sd200, neg: -14'sd100, post: 16'd20};
    cfg_b = '{edg: 1'b1, pos: 14'sd100, neg: -14'sd200, post: 16'd12};
    ctl_start_a = 1'b0;
    ctl_start_b = 1'b0;
    rd_en = 1'b0;
    rd_addr = '0;
    exp_in = '0;
    dn_in = '0;
    lvl = '0;
    armed = '0;
    trig_seen = '0;
    mdl_done = '0;
    ntrg = '{0, 0};
    seed = 32'hba56_bd3a;
    phase = 0;
    repeat (4) @(posedge sti);
    ctl_rst <= 1'b0;
    repeat (6) @(posedge sti);
    // idle after reset
    assert (!sts_trg_a && !sts_trg_b && !sts_done_a && !sts_done_b)
      else report_error("status high after reset");
    // disarmed channels, triggers still follow the level rule
    repeat (60) drive_sample();
    assert (!sts_done_a && !sts_done_b)
      else report_error("done without ctl_start");
    arm_channel(0, 1'b0, 200, -100, 20);
    arm_channel(1, 1'b1, 100, -200, 12);
    capture_until_done();
    check_buffer(0);
    check_buffer(1);
    // re-arm a, longer post count wraps the half
    arm_channel(0, 1'b0, 200, -100, 40);
    capture_until_done();
    check_buffer(0);
    check_buffer(1);
    if (ntrg[0] >= 3 && ntrg[1] >= 3) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      stop_run("stimulus produced too few triggers");
    end
  end

endmodule

`default_nettype wire

//--- rtl/scope_top.sv
/*
  scope trigger and acquisition top level
  two edge detector and acquisition channels on one shared buffer
*/

`default_nettype none

module scope_top import scope_pkg::*; #(
  parameter int buf_aw = 6
)(
  input  logic                    sti,
  input  logic                    ctl_rst,
  // ADC samples, one shared strobe
  input  smp_t                    adc_a,
  input  smp_t                    adc_b,
  // per-channel setup
  input  ch_cfg_t                 cfg_a,
  input  ch_cfg_t                 cfg_b,
  input  logic                    ctl_start_a,
  input  logic                    ctl_start_b,
  // status
  output logic                    sts_trg_a,
  output logic                    sts_trg_b,
  output logic                    sts_done_a,
  output logic                    sts_done_b,
  output logic [buf_aw-1:0]       sts_ptr_a,
  output logic [buf_aw-1:0]       sts_ptr_b,
  // readout
  input  logic                    rd_en,
  input  logic [buf_aw:0]         rd_addr,
  output logic signed [smp_w-1:0] rd_dat
);

  // tagged samples from the edge detectors
  tsmp_t tsmp_a;
  tsmp_t tsmp_b;

  // write side between controllers and buffer
  wr_req_t           wr_a;
  wr_req_t           wr_b;
  logic [buf_aw-1:0] addr_a;
  logic [buf_aw-1:0] addr_b;
  logic              gnt_a;
  logic              gnt_b;

  //////////////////////////////
  // channel a
  //////////////////////////////

  scope_edge edge_a (
    .sti     (sti),
    .ctl_rst (ctl_rst),
    .cfg     (cfg_a),
    .smp_i   (adc_a),
    .smp_o   (tsmp_a),
    .sts_trg (sts_trg_a)
  );

  scope_acq #(.buf_aw(buf_aw)) acq_a (
    .sti       (sti),
    .ctl_rst   (ctl_rst),
    .ctl_start (ctl_start_a),
    .cfg_post  (cfg_a.post),
    .smp       (tsmp_a),
    .wr        (wr_a),
    .wr_addr   (addr_a),
    .gnt       (gnt_a),
    .sts_done  (sts_done_a),
    .sts_ptr   (sts_ptr_a)
  );

  //////////////////////////////
  // channel b
  //////////////////////////////

  scope_edge edge_b (
    .sti     (sti),
    .ctl_rst (ctl_rst),
    .cfg     (cfg_b),
    .smp_i   (adc_b),
    .smp_o   (tsmp_b),
    .sts_trg (sts_trg_b)
  );

  scope_acq #(.buf_aw(buf_aw)) acq_b (
    .sti       (sti),
    .ctl_rst   (ctl_rst),
    .ctl_start (ctl_start_b),
    .cfg_post  (cfg_b.post),
    .smp       (tsmp_b),
    .wr        (wr_b),
    .wr_addr   (addr_b),
    .gnt       (gnt_b),
    .sts_done  (sts_done_b),
    .sts_ptr   (sts_ptr_b)
  );

  //////////////////////////////
  // shared buffer
  //////////////////////////////

  // one write port for both channels, readout on the other
  scope_buf #(.buf_aw(buf_aw)) sbuf (
    .sti     (sti),
    .ctl_rst (ctl_rst),
    .wr_a    (wr_a),
    .wr_b    (wr_b),
    .addr_a  (addr_a),
    .addr_b  (addr_b),
    .gnt_a   (gnt_a),
    .gnt_b   (gnt_b),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_dat  (rd_dat)
  );

endmodule

`default_nettype wire

//--- rtl/scope_buf.sv
/*
  shared sample memory for both channels
  round-robin arbiter on the single write port,
  registered read port for readout
*/

`default_nettype none

module scope_buf import scope_pkg::*; #(
  parameter int buf_aw = 6
)(
  input  logic                    sti,
  input  logic                    ctl_rst,
  // write requests from the two channels
  input  wr_req_t                 wr_a,
  input  wr_req_t                 wr_b,
  input  logic [buf_aw-1:0]       addr_a,
  input  logic [buf_aw-1:0]       addr_b,
  output logic                    gnt_a,
  output logic                    gnt_b,
  // readout, top address bit selects the channel
  input  logic                    rd_en,
  input  logic [buf_aw:0]         rd_addr,
  output logic signed [smp_w-1:0] rd_dat
);

  // both halves together
  localparam int depth = 2 ** (buf_aw + 1);

  // set: channel b wins a tie
  logic pri;

  // selected write
  logic                    wr_en;
  logic [buf_aw:0]         wr_addr;
  logic signed [smp_w-1:0] wr_dat;

  // sample storage
  logic signed [smp_w-1:0] mem [depth];

  //////////////////////////////
  // arbiter
  //////////////////////////////

  // a lone request always wins
  // on a tie the priority bit decides
  assign gnt_a = wr_a.req & (~wr_b.req | ~pri);
  assign gnt_b = wr_b.req & (~wr_a.req | pri);

  // last granted channel goes to the back
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      pri <= 1'b0;
    end else if (gnt_a) begin
      pri <= 1'b1;
    end else if (gnt_b) begin
      pri <= 1'b0;
    end
  end

  //////////////////////////////
  // write port
  //////////////////////////////

  assign wr_en = gnt_a | gnt_b;

  // channel number on top of the channel's own slot
  assign wr_addr = {gnt_b, gnt_b ? addr_b : addr_a};
  assign wr_dat  = gnt_b ? wr_b.dat : wr_a.dat;

  // written in the grant cycle
  always_ff @(posedge sti) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_dat;
    end
  end

  //////////////////////////////
  // read port
  //////////////////////////////

  // data one cycle after rd_en
  always_ff @(posedge sti) begin
    if (rd_en) begin
      rd_dat <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

//--- rtl/scope_acq.sv
/*
  per-channel acquisition controller
  circular write pointer over one half of the buffer,
  trigger pointer capture, post-trigger counter, done status
*/

`default_nettype none

module scope_acq import scope_pkg::*; #(
  parameter int buf_aw = 6
)(
  input  logic              sti,
  input  logic              ctl_rst,
  input  logic              ctl_start,
  input  logic [15:0]       cfg_post,
  input  tsmp_t             smp,
  output wr_req_t           wr,
  output logic [buf_aw-1:0] wr_addr,
  input  logic              gnt,
  output logic              sts_done,
  output logic [buf_aw-1:0] sts_ptr
);

  // FSM encoding
  localparam logic [1:0] st_idle = 2'd0;
  localparam logic [1:0] st_pre  = 2'd1;
  localparam logic [1:0] st_post = 2'd2;
  localparam logic [1:0] st_done = 2'd3;

  logic [1:0]        state;
  // next free slot in this channel's half
  logic [buf_aw-1:0] ptr;
  // samples written after the trigger
  logic [15:0]       cnt;
  logic [15:0]       cnt_nxt;
  logic              armed;
  logic              take;

  // pending write
  logic                    req_q;
  logic signed [smp_w-1:0] dat_q;

  // samples are recorded in both armed states
  assign armed   = (state == st_pre) || (state == st_post);
  assign take    = armed & smp.vld;
  assign cnt_nxt = cnt + 16'd1;

  //////////////////////////////
  // capture FSM
  //////////////////////////////

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      state    <= st_idle;
      ptr      <= '0;
      cnt      <= '0;
      sts_done <= 1'b0;
      sts_ptr  <= '0;
    end else if (ctl_start) begin
      // re-arm, pointer restarts at slot 0
      state    <= st_pre;
      ptr      <= '0;
      cnt      <= '0;
      sts_done <= 1'b0;
    end else begin
      // pointer wraps modulo the half size
      if (take) begin
        ptr <= ptr + 1'b1;
      end
      case (state)
        st_pre: begin
          // first trigger after arming
          if (smp.vld && smp.trg) begin
            sts_ptr <= ptr;
            state   <= (cfg_post == 16'd0) ? st_done : st_post;
          end
        end
        st_post: begin
          if (smp.vld) begin
            cnt <= cnt_nxt;
            if (cnt_nxt == cfg_post) begin
              state <= st_done;
            end
          end
        end
        st_done: begin
          // wait for the last write to land
          if (!req_q || gnt) begin
            sts_done <= 1'b1;
          end
        end
        default: begin
        end
      endcase
    end
  end

  //////////////////////////////
  // write request
  //////////////////////////////

  // held until the buffer grants it
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      req_q <= 1'b0;
    end else if (ctl_start) begin
      req_q <= 1'b0;
    end else if (take) begin
      req_q <= 1'b1;
    end else if (gnt) begin
      req_q <= 1'b0;
    end
  end

  // data and slot of the pending write
  always_ff @(posedge sti) begin
    if (take) begin
      dat_q   <= smp.dat;
      wr_addr <= ptr;
    end
  end

  assign wr = '{req: req_q, dat: dat_q};

endmodule

`default_nettype wire

//--- rtl/scope_edge.sv
/*
  per-channel edge trigger with hysteresis
  stage 1 subtracts the sample from both thresholds
  stage 2 tracks the level state and flags the trigger sample
*/

`default_nettype none

module scope_edge import scope_pkg::*; (
  input  logic    sti,
  input  logic    ctl_rst,
  input  ch_cfg_t cfg,
  input  smp_t    smp_i,
  output tsmp_t   smp_o,
  output logic    sts_trg
);

  // sign bit of the widened differences
  localparam int sgn = smp_w;

  // stage 1 results
  logic signed [sgn:0]     sub_pos;
  logic signed [sgn:0]     sub_neg;
  logic                    vld_s1;
  logic signed [smp_w-1:0] dat_s1;

  // stage 2 results
  logic                    vld_s2;
  logic signed [smp_w-1:0] dat_s2;
  logic                    trg_s2;

  // level state, current and next
  logic lvl_reg;
  logic lvl_nxt;
  // the threshold relevant to the current state was crossed
  logic thr_pass;

  //////////////////////////////
  // subtraction stage
  //////////////////////////////

  // strobe pipeline
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      vld_s1 <= 1'b0;
    end else begin
      vld_s1 <= smp_i.vld;
    end
  end

  // one bit wider, so the sign never overflows
  always_ff @(posedge sti) begin
    if (smp_i.vld) begin
      sub_pos <= cfg.pos - smp_i.dat;
      sub_neg <= smp_i.dat - cfg.neg;
      dat_s1  <= smp_i.dat;
    end
  end

  //////////////////////////////
  // trigger stage
  //////////////////////////////

  // rising low, falling high: look at pos
  // rising high, falling low: look at neg
  // negative difference means strictly past the threshold
  assign thr_pass = (cfg.edg ^ lvl_reg) ? sub_neg[sgn] : sub_pos[sgn];
  assign lvl_nxt  = lvl_reg ^ thr_pass;

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      lvl_reg <= 1'b0;
      vld_s2  <= 1'b0;
      trg_s2  <= 1'b0;
    end else begin
      vld_s2 <= vld_s1;
      // only the low to high transition fires
      trg_s2 <= vld_s1 & lvl_nxt & ~lvl_reg;
      if (vld_s1) begin
        lvl_reg <= lvl_nxt;
      end
    end
  end

  // data follows its flag through both stages
  always_ff @(posedge sti) begin
    if (vld_s1) begin
      dat_s2 <= dat_s1;
    end
  end

  assign smp_o   = '{vld: vld_s2, dat: dat_s2, trg: trg_s2};
  assign sts_trg = trg_s2;

endmodule

`default_nettype wire

//--- rtl/scope_pkg.sv
/*
  shared types of the two-channel scope trigger and acquisition
  sample width, input sample, trigger-tagged sample,
  per-channel configuration, buffer write request
*/

`default_nettype none

package scope_pkg;

  //////////////////////////////
  // sample format
  //////////////////////////////

  // ADC sample width in bits
  localparam int smp_w = 14;

  // one ADC sample with its strobe
  typedef struct packed {
    // strobe, one cycle per sample
    logic                    vld;
    // two's complement sample
    logic signed [smp_w-1:0] dat;
  } smp_t;

  // sample leaving the edge detector
  typedef struct packed {
    logic                    vld;
    logic signed [smp_w-1:0] dat;
    // set on the sample that fired the trigger
    logic                    trg;
  } tsmp_t;

  //////////////////////////////
  // configuration
  //////////////////////////////

  // per-channel trigger and capture setup
  typedef struct packed {
    // edge select, 0 rising, 1 falling
    logic                    edg;
    // upper hysteresis threshold
    logic signed [smp_w-1:0] pos;
    // lower hysteresis threshold
    logic signed [smp_w-1:0] neg;
    // samples kept after the trigger sample
    logic [15:0]             post;
  } ch_cfg_t;

  //////////////////////////////
  // buffer write side
  //////////////////////////////

  // write request from one acquisition controller
  // address goes on a separate port, its width is a module parameter
  typedef struct packed {
    // held high until granted
    logic                    req;
    logic signed [smp_w-1:0] dat;
  } wr_req_t;

endpackage

`default_nettype wire
